// File: paging_pkg.sv
`default_nettype none

package paging_pkg;

	// ====================
	// Memory models
	// ====================

	// Selected once, while reset is held
	typedef enum logic [2:0] {
		MODEL_128K  = 3'd0,
		MODEL_P1024 = 3'd1,
		MODEL_PROFI = 3'd2,
		MODEL_48K   = 3'd3,
		MODEL_PLUS3 = 3'd4
	} model_t;

	// ====================
	// Bus and bank types
	// ====================

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;

	// Bank number forms RAM address bits 24..14
	typedef logic [10:0] bank_t;
	typedef logic [24:0] ram_addr_t;

	// Mapping of one 16K CPU slot
	typedef struct packed {
		bank_t bank;
		logic  writable;
	} slot_map_t;

	// ====================
	// Paging constants
	// ====================

	localparam int NUM_SLOTS = 4;

	// Offset width inside a 16K slot
	localparam int SLOT_BITS = 14;

	// ROM pages sit at banks 101_pppp
	localparam logic [2:0] ROM_BANK_PREFIX = 3'b101;

	// Fixed RAM banks seen in slots 1 and 2 outside special mode
	localparam bank_t BANK_FIXED_SLOT1 = 11'd5;
	localparam bank_t BANK_FIXED_SLOT2 = 11'd2;

	// Profi memory extension port, fully decoded
	localparam cpu_addr_t PORT_PROFI_EXT = 16'hDFFD;

endpackage

`default_nettype wire

// File: page_state_if.sv
`timescale 1ns/1ns
`default_nettype none

// Paging register state, from the register block to the slot mappers
interface page_state_if;

	// Port 7FFD contents
	paging_pkg::byte_t page_reg;

	// Port 1FFD contents, +3 only
	paging_pkg::byte_t page_reg_plus3;

	// Upper RAM page bits for the 1024K models
	logic [2:0] page_128k;

	// ROM page for slot 0
	logic [3:0] rom_page;

	modport regs (
		output page_reg,
		output page_reg_plus3,
		output page_128k,
		output rom_page
	);

	modport slot (
		input page_reg,
		input page_reg_plus3,
		input page_128k,
		input rom_page
	);

endinterface

`default_nettype wire

// File: page_registers.sv
`timescale 1ns/1ns
`default_nettype none

module page_registers (
	input  wire                clk_sys,
	input  wire                reset,
	input  wire paging_pkg::model_t model,
	input  wire paging_pkg::cpu_addr_t addr,
	input  wire paging_pkg::byte_t cpu_dout,
	input  wire                io_wr,
	page_state_if.regs         state
);

	// ====================
	// Registers
	// ====================

	paging_pkg::model_t model_q;
	paging_pkg::byte_t  page_reg;
	paging_pkg::byte_t  page_reg_plus3;
	paging_pkg::byte_t  page_reg_p1024;
	logic [2:0]         page_128k;
	logic               old_wr;

	// Model flags
	logic is_p1024;
	logic is_profi;
	logic is_48k;
	logic is_plus3;

	// Decode
	logic locked;
	logic io_wr_rise;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_eff7;
	logic sel_dffd;

	assign is_p1024 = (model_q == paging_pkg::MODEL_P1024);
	assign is_profi = (model_q == paging_pkg::MODEL_PROFI);
	assign is_48k   = (model_q == paging_pkg::MODEL_48K);
	assign is_plus3 = (model_q == paging_pkg::MODEL_PLUS3);

	// 48K never pages; Pentagon needs EFF7 bit 2 before bit 5 locks
	assign locked = is_48k
		| (~is_p1024 & page_reg[5])
		| (is_p1024 & page_reg_p1024[2] & page_reg[5]);

	assign io_wr_rise = io_wr & ~old_wr;

	// 7FFD is only partly decoded; +3 also needs A14
	assign sel_7ffd = ~addr[15] & ~addr[1] & (addr[14] | ~is_plus3);

	// 1FFD
	assign sel_1ffd = ~addr[15] & ~addr[14] & ~addr[13] & addr[12] & ~addr[1] & is_plus3;

	// EFF7
	assign sel_eff7 = addr[15] & addr[14] & addr[13] & ~addr[12] & ~addr[3] & is_p1024;

	assign sel_dffd = (addr == paging_pkg::PORT_PROFI_EXT) & is_profi;

	// ====================
	// Port writes
	// ====================

	always_ff @(posedge clk_sys) begin
		old_wr <= io_wr;

		if (reset) begin
			model_q        <= model;
			page_reg       <= '0;
			page_reg_plus3 <= '0;
			page_reg_p1024 <= '0;
			page_128k      <= '0;
		end else if (io_wr_rise) begin
			if (sel_7ffd & ~locked) begin
				page_reg <= cpu_dout;
				// Pentagon takes bits 5,7,6 as the high page bits
				if (is_p1024 & ~page_reg_p1024[2])
					page_128k <= {cpu_dout[5], cpu_dout[7:6]};
			end else if (sel_1ffd & ~locked) begin
				page_reg_plus3 <= cpu_dout;
			end

			// Extension ports ignore the lock
			if (sel_dffd)
				page_128k <= cpu_dout[2:0];
			if (sel_eff7)
				page_reg_p1024 <= cpu_dout;
		end
	end

	// ====================
	// State out
	// ====================

	assign state.page_reg       = page_reg;
	assign state.page_reg_plus3 = page_reg_plus3;
	assign state.page_128k      = page_128k;

	// +3 has four ROMs, the others two
	assign state.rom_page = is_plus3 ? {2'b10, page_reg_plus3[2], page_reg[4]}
		: {3'b011, is_48k | page_reg[4]};

	// Locked 7FFD holds until the next reset
	assert property (@(posedge clk_sys) disable iff (reset)
		(locked && !reset) |=> $stable(page_reg))
		else $error("page_reg changed while paging is locked");

endmodule

`default_nettype wire

// File: slot_mapper.sv
`timescale 1ns/1ns
`default_nettype none

module slot_mapper #(
	parameter int SLOT = 0
) (
	page_state_if.slot           state,
	output paging_pkg::slot_map_t map
);

	localparam logic [1:0] IDX = SLOT[1:0];

	logic       special;
	logic [1:0] cfg;
	logic [2:0] special_bank;

	// All-RAM mode of the +3
	assign special = state.page_reg_plus3[0];
	assign cfg     = state.page_reg_plus3[2:1];

	// Special mode layouts: 0123, 4567, 4563, 4763
	always_comb begin
		case (cfg)
			2'b00: special_bank = {1'b0, IDX};
			2'b01: special_bank = {1'b1, IDX};
			2'b10: special_bank = (IDX == 2'd3) ? 3'd3 : {1'b1, IDX};
			default: begin
				if (IDX == 2'd3)
					special_bank = 3'd3;
				else if (IDX == 2'd1)
					special_bank = 3'd7;
				else
					special_bank = {1'b1, IDX};
			end
		endcase
	end

	always_comb begin
		if (special) begin
			map.bank     = {8'd0, special_bank};
			map.writable = 1'b1;
		end else begin
			map.writable = 1'b1;
			case (IDX)
				2'd0: begin
					// ROM, write protected
					map.bank     = {4'd0, paging_pkg::ROM_BANK_PREFIX, state.rom_page};
					map.writable = 1'b0;
				end
				2'd1: map.bank = paging_pkg::BANK_FIXED_SLOT1;
				2'd2: map.bank = paging_pkg::BANK_FIXED_SLOT2;
				default: map.bank = {5'd0, state.page_128k, state.page_reg[2:0]};
			endcase
		end
	end

endmodule

`default_nettype wire

// File: memory_request.sv
`timescale 1ns/1ns
`default_nettype none

module memory_request (
	input  wire paging_pkg::slot_map_t maps [paging_pkg::NUM_SLOTS],
	input  wire paging_pkg::cpu_addr_t addr,
	input  wire                  mem_rd,
	input  wire                  mem_wr,
	output paging_pkg::ram_addr_t ram_addr,
	output logic                 ram_rd,
	output logic                 ram_we
);

	paging_pkg::slot_map_t sel;

	// ====================
	// Slot select
	// ====================

	always_comb begin
		// Top two address bits pick the 16K slot
		sel = maps[addr[15:14]];

		ram_addr = {sel.bank, addr[paging_pkg::SLOT_BITS-1:0]};
		ram_rd   = mem_rd;
		ram_we   = mem_wr & sel.writable;
	end

endmodule

`default_nettype wire

// File: memory_pager.sv
`timescale 1ns/1ns
`default_nettype none

module memory_pager (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire paging_pkg::model_t    model,
	input  wire paging_pkg::cpu_addr_t addr,
	input  wire paging_pkg::byte_t     cpu_dout,
	input  wire                   io_wr,
	input  wire                   mem_rd,
	input  wire                   mem_wr,
	output paging_pkg::ram_addr_t ram_addr,
	output logic                  ram_rd,
	output logic                  ram_we,
	output logic                  scr_page
);

	// ====================
	// Paging registers
	// ====================

	page_state_if state ();

	page_registers u_page_registers (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.model    (model),
		.addr     (addr),
		.cpu_dout (cpu_dout),
		.io_wr    (io_wr),
		.state    (state.regs)
	);

	// Shadow screen in bank 7 when set
	assign scr_page = state.page_reg[3];

	// ====================
	// Slot mapping
	// ====================

	paging_pkg::slot_map_t maps [paging_pkg::NUM_SLOTS];

	for (genvar i = 0; i < paging_pkg::NUM_SLOTS; i++) begin : g_slot
		slot_mapper #(
			.SLOT (i)
		) u_slot_mapper (
			.state (state.slot),
			.map   (maps[i])
		);
	end

	// ====================
	// RAM request
	// ====================

	memory_request u_memory_request (
		.maps     (maps),
		.addr     (addr),
		.mem_rd   (mem_rd),
		.mem_wr   (mem_wr),
		.ram_addr (ram_addr),
		.ram_rd   (ram_rd),
		.ram_we   (ram_we)
	);

endmodule

`default_nettype wire

// File: tb_memory_pager.sv
`timescale 1ns/1ns
`default_nettype none

module tb_memory_pager;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int RESET_TIMEOUT = 100;
	localparam logic [31:0] LFSR_SEED = 32'hc2db8aaa;

	// Special mode banks, one octal digit per slot, slot 0 leftmost
	localparam logic [3:0][11:0] SPECIAL_LAYOUT = {12'o4763, 12'o4563, 12'o4567, 12'o0123};

	logic                  clk_sys;
	logic                  reset;
	paging_pkg::model_t    model;
	paging_pkg::cpu_addr_t addr;
	paging_pkg::byte_t     cpu_dout;
	logic                  io_wr;
	logic                  mem_rd;
	logic                  mem_wr;
	paging_pkg::ram_addr_t ram_addr;
	logic                  ram_rd;
	logic                  ram_we;
	logic                  scr_page;

	// Reference copy of the paging registers
	paging_pkg::model_t ref_model;
	paging_pkg::byte_t  ref_page;
	paging_pkg::byte_t  ref_plus3;
	paging_pkg::byte_t  ref_ext;
	logic [2:0]         ref_128k;

	// Expected response of the access in flight
	logic                  check_en;
	paging_pkg::ram_addr_t exp_addr;
	logic                  exp_we;
	logic                  exp_rd;
	logic                  exp_scr;
	int                    num_checks;
	int                    num_accesses;

	logic [31:0] lfsr;
	event        start_reset;

	memory_pager i_dut (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.model    (model),
		.addr     (addr),
		.cpu_dout (cpu_dout),
		.io_wr    (io_wr),
		.mem_rd   (mem_rd),
		.mem_wr   (mem_wr),
		.ram_addr (ram_addr),
		.ram_rd   (ram_rd),
		.ram_we   (ram_we),
		.scr_page (scr_page)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Reset held for a fixed count, restarted on request
	initial begin
		reset = 1'b1;
		forever begin
			repeat (RESET_CYCLES) @(negedge clk_sys);
			reset = 1'b0;
			@(start_reset);
			reset = 1'b1;
		end
	end

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_ram_addr(input paging_pkg::ram_addr_t got,
			input paging_pkg::ram_addr_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %07h, expected %07h", $time, what, got, exp);
			abort_run("RAM address mismatch");
		end
	endtask

	task automatic check_strobe(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			abort_run("strobe mismatch");
		end
	endtask

	task automatic check_scr(input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: scr_page is %b, expected %b", $time, got, exp);
			abort_run("screen page mismatch");
		end
	endtask

	// ====================
	// Reference model
	// ====================

	task automatic ref_reset(input paging_pkg::model_t m);
		ref_model = m;
		ref_page  = '0;
		ref_plus3 = '0;
		ref_ext   = '0;
		ref_128k  = '0;
	endtask

	task automatic ref_port_write(input paging_pkg::cpu_addr_t p, input paging_pkg::byte_t d);
		logic locked;
		logic hit_7ffd;
		logic hit_1ffd;
		locked = (ref_model == paging_pkg::MODEL_48K)
			|| (ref_model != paging_pkg::MODEL_P1024 && ref_page[5])
			|| (ref_model == paging_pkg::MODEL_P1024 && ref_ext[2] && ref_page[5]);
		hit_7ffd = !p[15] && !p[1] && (p[14] || ref_model != paging_pkg::MODEL_PLUS3);
		hit_1ffd = ref_model == paging_pkg::MODEL_PLUS3 && p[15:12] == 4'b0001 && !p[1];
		if (!locked && hit_7ffd) begin
			ref_page = d;
			if (ref_model == paging_pkg::MODEL_P1024 && !ref_ext[2])
				ref_128k = {d[5], d[7], d[6]};
		end else if (!locked && hit_1ffd) begin
			ref_plus3 = d;
		end
		if (ref_model == paging_pkg::MODEL_PROFI && p == 16'hDFFD)
			ref_128k = d[2:0];
		if (ref_model == paging_pkg::MODEL_P1024 && p[15:12] == 4'b1110 && !p[3])
			ref_ext = d;
	endtask

	// Returns {ram_we, ram_addr}
	function automatic logic [25:0] ref_request(input paging_pkg::cpu_addr_t a, input logic wr);
		logic [1:0]        s;
		logic [3:0]        rom;
		logic [11:0]       layout;
		int                idx;
		paging_pkg::bank_t b;
		logic              w;
		s = a[15:14];
		if (ref_model == paging_pkg::MODEL_PLUS3)
			rom = {2'b10, ref_plus3[2], ref_page[4]};
		else
			rom = {3'b011, (ref_model == paging_pkg::MODEL_48K) | ref_page[4]};
		w = 1'b1;
		if (ref_plus3[0]) begin
			layout = SPECIAL_LAYOUT[ref_plus3[2:1]];
			idx = 11 - 3 * int'(s);
			b = {8'd0, layout[idx -: 3]};
		end else if (s == 2'd0) begin
			b = {4'd0, 3'b101, rom};
			w = 1'b0;
		end else if (s == 2'd1) begin
			b = 11'd5;
		end else if (s == 2'd2) begin
			b = 11'd2;
		end else begin
			b = {5'd0, ref_128k, ref_page[2:0]};
		end
		return {wr & w, b, a[13:0]};
	endfunction

	// Compare each access half a cycle after it is driven
	always @(posedge clk_sys) begin
		if (check_en) begin
			check_ram_addr(ram_addr, exp_addr, "ram_addr");
			check_strobe(ram_we, exp_we, "ram_we");
			check_strobe(ram_rd, exp_rd, "ram_rd");
			check_scr(scr_page, exp_scr);
			num_checks++;
		end
	end

	// ====================
	// Stimulus
	// ====================

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		@(posedge clk_sys);
		while (reset) begin
			if (cycles == RESET_TIMEOUT)
				abort_run("reset was never released");
			@(posedge clk_sys);
			cycles++;
		end
	endtask

	task automatic restart(input paging_pkg::model_t m);
		@(negedge clk_sys);
		check_en = 1'b0;
		mem_rd   = 1'b0;
		mem_wr   = 1'b0;
		io_wr    = 1'b0;
		model    = m;
		ref_reset(m);
		-> start_reset;
		wait_reset_release();
	endtask

	task automatic port_write(input paging_pkg::cpu_addr_t p, input paging_pkg::byte_t d);
		@(negedge clk_sys);
		check_en = 1'b0;
		mem_rd   = 1'b0;
		mem_wr   = 1'b0;
		addr     = p;
		cpu_dout = d;
		io_wr    = 1'b1;
		@(negedge clk_sys);
		io_wr = 1'b0;
		ref_port_write(p, d);
	endtask

	task automatic do_access(input logic [1:0] slot, input logic wr);
		logic [31:0] r;
		rand_bits(14, r);
		@(negedge clk_sys);
		addr   = {slot, r[13:0]};
		mem_rd = ~wr;
		mem_wr = wr;
		{exp_we, exp_addr} = ref_request({slot, r[13:0]}, wr);
		exp_rd   = ~wr;
		exp_scr  = ref_page[3];
		check_en = 1'b1;
		num_accesses++;
	endtask

	task automatic sweep_slots();
		int s;
		for (s = 0; s < paging_pkg::NUM_SLOTS; s++) begin
			do_access(s[1:0], 1'b0);
			do_access(s[1:0], 1'b1);
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] p;
		int          i;
		model        = paging_pkg::MODEL_128K;
		addr         = '0;
		cpu_dout     = '0;
		io_wr        = 1'b0;
		mem_rd       = 1'b0;
		mem_wr       = 1'b0;
		check_en     = 1'b0;
		exp_addr     = '0;
		exp_we       = 1'b0;
		exp_rd       = 1'b0;
		exp_scr      = 1'b0;
		num_checks   = 0;
		num_accesses = 0;
		lfsr         = LFSR_SEED;
		ref_reset(paging_pkg::MODEL_128K);
		wait_reset_release();

		// Standard 128K, reset mapping then 7FFD paging and lock
		sweep_slots();
		for (i = 0; i < 12; i++) begin
			rand_bits(16, p);
			rand_bits(8, r);
			port_write(p[15:0] & 16'h7FFD, r[7:0] & 8'hDF);
			sweep_slots();
		end
		rand_bits(8, r);
		port_write(16'h7FFD, r[7:0] | 8'h20);
		sweep_slots();
		for (i = 0; i < 6; i++) begin
			rand_bits(8, r);
			port_write(16'h7FFD, r[7:0]);
			sweep_slots();
		end

		// +3 special configurations, then ROM selection
		restart(paging_pkg::MODEL_PLUS3);
		for (i = 0; i < 4; i++) begin
			port_write(16'h1FFD, {5'd0, i[1:0], 1'b1});
			sweep_slots();
		end
		for (i = 0; i < 4; i++) begin
			port_write(16'h1FFD, {5'd0, i[1], 2'b00});
			port_write(16'h7FFD, {3'b000, i[0], 4'h3});
			sweep_slots();
		end
		// A14 low is not 7FFD on the +3
		port_write(16'h3FFD, 8'h07);
		sweep_slots();

		// Pentagon 1024K extension and EFF7 freeze
		restart(paging_pkg::MODEL_P1024);
		for (i = 0; i < 8; i++) begin
			rand_bits(8, r);
			port_write(16'h7FFD, r[7:0]);
			sweep_slots();
		end
		port_write(16'hEFF7, 8'h04);
		rand_bits(8, r);
		port_write(16'h7FFD, r[7:0] & 8'hDF);
		sweep_slots();
		port_write(16'h7FFD, 8'hE5);
		port_write(16'h7FFD, 8'h02);
		sweep_slots();

		// Profi 1024K, DFFD ignores the lock
		restart(paging_pkg::MODEL_PROFI);
		for (i = 0; i < 6; i++) begin
			rand_bits(8, r);
			port_write(16'hDFFD, r[7:0]);
			rand_bits(8, r);
			port_write(16'h7FFD, r[7:0] & 8'hDF);
			sweep_slots();
		end
		port_write(16'h7FFD, 8'h21);
		port_write(16'hDFFD, 8'h06);
		sweep_slots();

		// 48K never pages
		restart(paging_pkg::MODEL_48K);
		for (i = 0; i < 6; i++) begin
			rand_bits(16, p);
			rand_bits(8, r);
			port_write(p[15:0] & 16'h7FFD, r[7:0]);
			sweep_slots();
		end

		@(negedge clk_sys);
		check_en = 1'b0;
		mem_rd   = 1'b0;
		mem_wr   = 1'b0;
		@(negedge clk_sys);
		if (num_checks == num_accesses) begin
			$display("test passed");
			$finish;
		end else begin
			$display("not every memory access driven was also compared");
			$display("test failed");
			$fatal(1, "simulation stopped");
		end
	end

endmodule

`default_nettype wire

// File: sim.f
paging_pkg.sv
page_state_if.sv
page_registers.sv
slot_mapper.sv
memory_request.sv
memory_pager.sv
tb_memory_pager.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_memory_pager
LOG ?= sim.log
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
